// ==== tb.f ====
+incdir+common
common/apb_pkg.sv
common/mem_pkg.sv
mem_1rw_sync/clk_gate.sv
mem_1rw_sync/mem_1r1w.sv
mem_1rw_sync/mem_1rw_synth.sv
mem_1rw_sync/mem_1rw_sync.sv
verilog/apb_scratch_bridge.sv
verilog/apb_scratch_top.sv
tb/tb_apb_scratch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the APB scratchpad testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_apb_scratch -Mdir obj_dir

if ./obj_dir/Vtb_apb_scratch | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null
then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tb/tb_apb_scratch.sv ====
// ########################################
// APB scratchpad testbench
// drives APB transfers, keeps a memory
// model and checks with assertions
// ########################################

`timescale 1ns/1ps
`include "scratch_defs.svh"

module tb_apb_scratch;
  import apb_pkg::*;

  localparam int unsigned WORDS    = `SCRATCH_BANKS * `SCRATCH_BANK_ROWS;
  localparam int          TIMEOUT  = 20;
  localparam int          N_RANDOM = 200;
  localparam int          N_BAD    = 12;
  localparam logic [31:0] SEED     = 32'h656e_cc15;

  logic     clk_lo;
  logic     rst_n_i;
  apb_req_s apb_req;
  apb_rsp_s apb_rsp;
  logic     setup_phase;
  logic     access_phase;

  // expected response of the transfer in flight
  logic                       exp_err;
  logic [`SCRATCH_WORD_W-1:0] exp_rdata;

  logic [`SCRATCH_WORD_W-1:0] model [int];
  logic [31:0]                lfsr_state;
  int                         err_cnt;
  int                         timeout_cnt;
  int                         xfer_cnt;
  int                         read_cnt;
  bit                         stop_run;

  apb_scratch_top UUT (
    .clk_lo    (clk_lo),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  always #4 clk_lo = ~clk_lo;

  assign setup_phase  = apb_req.psel && !apb_req.penable;
  assign access_phase = apb_req.psel && apb_req.penable;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // one step per bit, newest bit at the bottom
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // legal is word aligned and below 0x800
  function automatic logic addr_is_bad(input logic [`SCRATCH_ADDR_W-1:0] a);
    return (a[1:0] != 2'b00) || (int'(a) >= int'(WORDS * 4));
  endfunction

  task automatic apb_transfer(input logic wr, input logic [`SCRATCH_ADDR_W-1:0] addr,
                              input logic [`SCRATCH_WORD_W-1:0] wdata);
    int   waited;
    int   key;
    logic bad;
    bad = addr_is_bad(addr);
    key = int'(addr >> 2);
    if (!stop_run)
    begin
      @(posedge clk_lo);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= wr;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      exp_err         <= bad;
      exp_rdata       <= (!wr && !bad && model.exists(key)) ? model[key] : '0;
      @(posedge clk_lo);
      apb_req.penable <= 1'b1;
      // pready is looked at on the falling edge, away from the driving edge
      waited = 0;
      @(negedge clk_lo);
      while (!apb_rsp.pready && waited < TIMEOUT)
      begin
        @(negedge clk_lo);
        waited++;
      end
      if (!apb_rsp.pready)
      begin
        $display("timeout: no pready within %0d cycles for address %h", TIMEOUT, addr);
        timeout_cnt++;
        stop_run = 1'b1;
      end
      else
      begin
        xfer_cnt++;
        if (wr && !bad)
          model[key] = wdata;
        if (!wr && !bad)
          read_cnt++;
      end
      @(posedge clk_lo);
      apb_req <= '0;
    end
  endtask

  task automatic end_run();
    $display("transfers %0d, reads %0d, errors %0d, timeouts %0d",
             xfer_cnt, read_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  // nothing comes back while no transfer is selected
  a_idle_quiet: assert property (@(posedge clk_lo) disable iff (!rst_n_i)
    !apb_req.psel |-> (!apb_rsp.pready && !apb_rsp.pslverr))
    else
    begin
      err_cnt++;
      $display("Fail %0t: pready or pslverr high with no transfer selected", $time);
    end

  // exactly one wait state
  a_ready_late: assert property (@(posedge clk_lo) disable iff (!rst_n_i)
    ($past(setup_phase, 2) && $past(access_phase, 1) && access_phase) |-> apb_rsp.pready)
    else
    begin
      err_cnt++;
      $display("Fail %0t: pready missing two cycles after setup", $time);
    end

  a_ready_early: assert property (@(posedge clk_lo) disable iff (!rst_n_i)
    apb_rsp.pready |-> ($past(setup_phase, 2) && $past(access_phase, 1) && access_phase))
    else
    begin
      err_cnt++;
      $display("Fail %0t: pready outside the second access cycle", $time);
    end

  a_err_flag: assert property (@(posedge clk_lo) disable iff (!rst_n_i)
    apb_rsp.pready |-> (apb_rsp.pslverr == exp_err))
    else
    begin
      err_cnt++;
      $display("Fail %0t: pslverr %b for address %h, expected %b", $time,
               $sampled(apb_rsp.pslverr), $sampled(apb_req.paddr), $sampled(exp_err));
    end

  a_read_data: assert property (@(posedge clk_lo) disable iff (!rst_n_i)
    (apb_rsp.pready && !apb_req.pwrite && !exp_err) |-> (apb_rsp.prdata == exp_rdata))
    else
    begin
      err_cnt++;
      $display("Fail %0t: read %h at address %h, expected %h", $time,
               $sampled(apb_rsp.prdata), $sampled(apb_req.paddr), $sampled(exp_rdata));
    end

  initial
  begin
    logic [31:0]                rnd;
    logic [`SCRATCH_ADDR_W-1:0] addr;
    logic [`SCRATCH_WORD_W-1:0] data;
    logic                       wr;
    clk_lo      = 1'b0;
    rst_n_i     = 1'b0;
    apb_req     = '0;
    exp_err     = 1'b0;
    exp_rdata   = '0;
    lfsr_state  = SEED;
    err_cnt     = 0;
    timeout_cnt = 0;
    xfer_cnt    = 0;
    read_cnt    = 0;
    stop_run    = 1'b0;
    repeat (5) @(posedge clk_lo);
    rst_n_i <= 1'b1;
    // a few idle cycles so the quiet bus after reset is seen
    repeat (4) @(posedge clk_lo);

    // write then read in bank 0 and in bank 1, including the bank edges
    apb_transfer(1'b1, 12'h010, 32'hdead_0b00);
    apb_transfer(1'b0, 12'h010, '0);
    apb_transfer(1'b1, 12'h410, 32'hbeef_0b01);
    apb_transfer(1'b0, 12'h410, '0);
    apb_transfer(1'b1, 12'h3fc, 32'h0000_03fc);
    apb_transfer(1'b1, 12'h400, 32'h0000_0400);
    apb_transfer(1'b1, 12'h7fc, 32'h0000_07fc);
    apb_transfer(1'b0, 12'h3fc, '0);
    apb_transfer(1'b0, 12'h400, '0);
    apb_transfer(1'b0, 12'h7fc, '0);

    // random mix over the whole legal range, reads only where written
    for (int i = 0; i < N_RANDOM; i++)
    begin
      rnd  = take_bits(9);
      addr = {rnd[8:0], 2'b00};
      rnd  = take_bits(1);
      wr   = rnd[0] || !model.exists(int'(addr >> 2));
      data = take_bits(32);
      apb_transfer(wr, addr, wr ? data : '0);
    end

    // out of range and misaligned, which alias onto written rows
    apb_transfer(1'b1, 12'h800, 32'hbad0_0001);
    apb_transfer(1'b0, 12'hffc, '0);
    apb_transfer(1'b1, 12'h012, 32'hbad0_0002);
    apb_transfer(1'b1, 12'h401, 32'hbad0_0003);
    for (int i = 0; i < N_BAD; i++)
    begin
      rnd  = take_bits(12);
      addr = rnd[11:0];
      if (!addr_is_bad(addr))
        addr[0] = 1'b1;
      data = take_bits(32);
      apb_transfer(1'b1, addr, data);
    end

    // every written word must be untouched by the rejected writes
    foreach (model[k])
      apb_transfer(1'b0, `SCRATCH_ADDR_W'(k << 2), '0);

    repeat (2) @(posedge clk_lo);
    end_run();
  end

endmodule

// ==== verilog/apb_scratch_top.sv ====
// ######################################
// APB scratchpad top
// bridge plus two single-port banks,
// gated two-port build and plain build
// ######################################

`timescale 1ns/1ps
`include "scratch_defs.svh"

module apb_scratch_top
(
  input  logic              clk_lo,
  input  logic              rst_n_i,
  input  apb_pkg::apb_req_s apb_req_i,
  output apb_pkg::apb_rsp_s apb_rsp_o
);
  import mem_pkg::*;

  mem_req_s bank_req   [`SCRATCH_BANKS];
  word_t    bank_rdata [`SCRATCH_BANKS];

  apb_scratch_bridge u_bridge (
    .clk_lo       (clk_lo),
    .rst_n_i      (rst_n_i),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .bank_req_o   (bank_req),
    .bank_rdata_i (bank_rdata)
  );

  // bank 0 on the two-port substitute behind a clock gate
  mem_1rw_sync #(
    .width_p               (`SCRATCH_WORD_W),
    .els_p                 (`SCRATCH_BANK_ROWS),
    .substitute_1r1w_p     (1'b1),
    .enable_clock_gating_p (1'b1)
  ) u_bank0 (
    .clk_lo    (clk_lo),
    .rst_n_i   (rst_n_i),
    .req_i     (bank_req[0]),
    .rd_data_o (bank_rdata[0])
  );

  // bank 1 on the plain synthesizable array, free-running clock
  mem_1rw_sync #(
    .width_p               (`SCRATCH_WORD_W),
    .els_p                 (`SCRATCH_BANK_ROWS),
    .substitute_1r1w_p     (1'b0),
    .enable_clock_gating_p (1'b0)
  ) u_bank1 (
    .clk_lo    (clk_lo),
    .rst_n_i   (rst_n_i),
    .req_i     (bank_req[1]),
    .rd_data_o (bank_rdata[1])
  );

endmodule

// ==== verilog/apb_scratch_bridge.sv ====
// ######################################
// APB to scratchpad bridge
// decodes bank and row, checks the
// address, issues one request per
// transfer and forms the response
// ######################################

`timescale 1ns/1ps
`include "scratch_defs.svh"

module apb_scratch_bridge
(
  input  logic              clk_lo,
  input  logic              rst_n_i,
  input  apb_pkg::apb_req_s apb_req_i,
  output apb_pkg::apb_rsp_s apb_rsp_o,
  output mem_pkg::mem_req_s bank_req_o [`SCRATCH_BANKS],
  input  mem_pkg::word_t    bank_rdata_i [`SCRATCH_BANKS]
);
  import mem_pkg::*;

  localparam int unsigned WIDX_W = `SCRATCH_ADDR_W - 2;
  localparam int unsigned BANK_W = $clog2(`SCRATCH_BANKS);
  localparam int unsigned WORDS  = `SCRATCH_BANKS * `SCRATCH_BANK_ROWS;

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_RESPOND} state_e;

  state_e                    state_q;
  state_e                    state_d;
  logic [WIDX_W-1:0]         word_idx;
  logic [ROW_W-1:0]          row;
  logic [BANK_W-1:0]         bank_sel;
  logic [BANK_W-1:0]         bank_q;
  logic                      addr_ok;
  logic                      err_q;
  logic [`SCRATCH_BANKS-1:0] bank_v;

  // byte address to word index, then bank above row
  assign word_idx = apb_req_i.paddr[`SCRATCH_ADDR_W-1:2];
  assign row      = word_idx[ROW_W-1:0];
  assign bank_sel = word_idx[ROW_W +: BANK_W];
  assign addr_ok  = (apb_req_i.paddr[1:0] == 2'b00) && (word_idx < WIDX_W'(WORDS));

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (apb_req_i.psel && !apb_req_i.penable) state_d = ST_ISSUE;
      ST_ISSUE:   state_d = ST_RESPOND;
      ST_RESPOND: state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_lo or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= ST_IDLE;
      bank_q  <= '0;
      err_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // keep the decode for the response cycle
      if (state_q == ST_ISSUE)
      begin
        bank_q <= bank_sel;
        err_q  <= ~addr_ok;
      end
    end
  end

  // request goes out in the first access cycle, only for a legal address
  for (genvar b = 0; b < `SCRATCH_BANKS; b++)
  begin : g_bank
    assign bank_v[b]     = (state_q == ST_ISSUE) && addr_ok && (bank_sel == BANK_W'(b));
    assign bank_req_o[b] = '{v: bank_v[b], w: apb_req_i.pwrite, addr: row,
                             data: apb_req_i.pwdata};
  end

  always_comb
  begin
    apb_rsp_o = '0;
    if (state_q == ST_RESPOND)
    begin
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = err_q;
      if (!err_q && !apb_req_i.pwrite)
        apb_rsp_o.prdata = bank_rdata_i[bank_q];
    end
  end

  a_ready_in_access: assert property (@(posedge clk_lo) disable iff (!rst_n_i)
    apb_rsp_o.pready |-> (apb_req_i.psel && apb_req_i.penable))
    else $error("bridge: pready outside an access phase");

  // master must hold the transfer until it sees pready
  a_req_stable: assert property (@(posedge clk_lo) disable iff (!rst_n_i)
    (apb_req_i.psel && !apb_rsp_o.pready) |=>
      ($stable(apb_req_i.paddr) && $stable(apb_req_i.pwrite) && $stable(apb_req_i.pwdata)))
    else $error("bridge: request changed while pending");

endmodule

// ==== mem_1rw_sync/mem_1rw_sync.sv ====
// ######################################
// single-port synchronous RAM wrapper
// builds on a two-port array with a
// registered output or on a plain array,
// with an optional request clock gate
// ######################################

`timescale 1ns/1ps
`include "scratch_defs.svh"

module mem_1rw_sync #(
  parameter int unsigned width_p               = `SCRATCH_WORD_W,
  parameter int unsigned els_p                 = `SCRATCH_BANK_ROWS,
  parameter bit          substitute_1r1w_p     = 1'b1,
  parameter bit          enable_clock_gating_p = 1'b0
)
(
  input  logic              clk_lo,
  input  logic              rst_n_i,
  input  mem_pkg::mem_req_s req_i,
  output mem_pkg::word_t    rd_data_o
);
  localparam int unsigned addr_w_lp = $clog2(els_p);

  logic                 clk_mem;
  logic [addr_w_lp-1:0] addr;

  assign addr = req_i.addr[addr_w_lp-1:0];

  // the array only sees edges on cycles that carry a request
  if (enable_clock_gating_p)
  begin : g_gate
    clk_gate u_icg (
      .clk_lo      (clk_lo),
      .en_i        (req_i.v),
      .gated_clk_o (clk_mem)
    );
  end
  else
  begin : g_nogate
    assign clk_mem = clk_lo;
  end

  if (substitute_1r1w_p)
  begin : g_s1r1w
    logic [width_p-1:0] r_data;

    // one port pair on the same row, never both in a cycle
    mem_1r1w #(.width_p(width_p), .els_p(els_p)) u_mem (
      .clk_lo   (clk_mem),
      .rst_n_i  (rst_n_i),
      .w_v_i    (req_i.v & req_i.w),
      .w_addr_i (addr),
      .w_data_i (req_i.data),
      .r_v_i    (req_i.v & ~req_i.w),
      .r_addr_i (addr),
      .r_data_o (r_data)
    );

    // async read made synchronous, held between reads
    always_ff @(posedge clk_mem or negedge rst_n_i)
    begin
      if (!rst_n_i)
        rd_data_o <= '0;
      else if (req_i.v && !req_i.w)
        rd_data_o <= r_data;
    end
  end
  else
  begin : g_synth
    mem_1rw_synth #(.width_p(width_p), .els_p(els_p)) u_mem (
      .clk_lo    (clk_mem),
      .rst_n_i   (rst_n_i),
      .req_i     (req_i),
      .rd_data_o (rd_data_o)
    );
  end

  a_addr_range: assert property (@(posedge clk_lo) disable iff (!rst_n_i)
    req_i.v |-> (req_i.addr < els_p))
    else $error("mem_1rw_sync: row %0d beyond %0d entries", req_i.addr, els_p);

endmodule

// ==== mem_1rw_sync/mem_1rw_synth.sv ====
// ######################################
// synthesizable single-port array
// output register loads on reads only
// ######################################

`timescale 1ns/1ps

module mem_1rw_synth #(
  parameter int unsigned width_p = 32,
  parameter int unsigned els_p   = 256
)
(
  input  logic              clk_lo,
  input  logic              rst_n_i,
  input  mem_pkg::mem_req_s req_i,
  output mem_pkg::word_t    rd_data_o
);
  localparam int unsigned addr_w_lp = $clog2(els_p);

  logic [width_p-1:0]   mem [els_p];
  logic [addr_w_lp-1:0] addr;
  logic                 wr_en;
  logic                 rd_en;

  assign addr  = req_i.addr[addr_w_lp-1:0];
  assign wr_en = req_i.v & req_i.w;
  assign rd_en = req_i.v & ~req_i.w;

  // storage array written on write requests
  always_ff @(posedge clk_lo)
  begin
    if (wr_en)
      mem[addr] <= req_i.data;
  end

  // last read word stays on the output until the next read
  always_ff @(posedge clk_lo or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_data_o <= '0;
    end
    else if (rd_en)
    begin
      rd_data_o <= mem[addr];
    end
  end

endmodule

// ==== mem_1rw_sync/mem_1r1w.sv ====
// ######################################
// two-port register array
// clocked write port, async read port
// ######################################

`timescale 1ns/1ps

module mem_1r1w #(
  parameter int unsigned width_p   = 32,
  parameter int unsigned els_p     = 256,
  parameter int unsigned addr_w_lp = $clog2(els_p)
)
(
  input  logic                 clk_lo,
  input  logic                 rst_n_i,
  input  logic                 w_v_i,
  input  logic [addr_w_lp-1:0] w_addr_i,
  input  logic [width_p-1:0]   w_data_i,
  input  logic                 r_v_i,
  input  logic [addr_w_lp-1:0] r_addr_i,
  output logic [width_p-1:0]   r_data_o
);

  logic [width_p-1:0] mem [els_p];

  always_ff @(posedge clk_lo)
  begin
    if (w_v_i)
      mem[w_addr_i] <= w_data_i;
  end

  // read is combinational
  // an idle read port returns zero so nothing stale leaks out
  always_comb
  begin
    if (r_v_i)
      r_data_o = mem[r_addr_i];
    else
      r_data_o = '0;
  end

  // a same-row read during a write would see the old word
  a_no_rw_collision: assert property (@(posedge clk_lo) disable iff (!rst_n_i)
    !(w_v_i && r_v_i && (w_addr_i == r_addr_i)))
    else $error("mem_1r1w: read and write of row %0d in one cycle", r_addr_i);

endmodule

// ==== mem_1rw_sync/clk_gate.sv ====
// ######################################
// latch-based clock gate
// ######################################

`timescale 1ns/1ps

module clk_gate
(
  input  logic clk_lo,
  input  logic en_i,
  output logic gated_clk_o
);

  logic en_latch;

  // enable is sampled while the clock is low
  // so it cannot change during the high phase
  always_latch
  begin
    if (!clk_lo)
      en_latch <= en_i;
  end

  assign gated_clk_o = clk_lo & en_latch;

endmodule

// ==== common/mem_pkg.sv ====
// ######################################
// memory types
// word type and single-port request
// ######################################

`include "scratch_defs.svh"

package mem_pkg;

  // row index width inside one bank
  localparam int unsigned ROW_W = $clog2(`SCRATCH_BANK_ROWS);

  typedef logic [`SCRATCH_WORD_W-1:0] word_t;

  // v qualifies the request, w selects write over read
  typedef struct packed {
    logic             v;
    logic             w;
    logic [ROW_W-1:0] addr;
    word_t            data;
  } mem_req_s;

endpackage

// ==== common/apb_pkg.sv ====
// ######################################
// APB types
// request and response bundles of the
// outside APB port
// ######################################

`include "scratch_defs.svh"

package apb_pkg;

  // driven by the master, held until pready
  typedef struct packed {
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`SCRATCH_ADDR_W-1:0] paddr;
    logic [`SCRATCH_WORD_W-1:0] pwdata;
  } apb_req_s;

  // driven by the slave
  // prdata and pslverr only count while pready is high
  typedef struct packed {
    logic [`SCRATCH_WORD_W-1:0] prdata;
    logic                       pready;
    logic                       pslverr;
  } apb_rsp_s;

endpackage

// ==== common/scratch_defs.svh ====
// ######################################
// scratchpad sizing
// word width, bank geometry and the APB
// address width shared by the design
// ######################################

`ifndef SCRATCH_DEFS_SVH
`define SCRATCH_DEFS_SVH

// data word in bits
`define SCRATCH_WORD_W 32
// words held by one bank
`define SCRATCH_BANK_ROWS 256
// number of banks behind the bridge
`define SCRATCH_BANKS 2
// byte address width on the APB side
`define SCRATCH_ADDR_W 12

`endif
